//--- bench/clr_testdata.txt
# W = wipe, B = wipe with a second wipe pulse while busy
# R gap0 chunk0 gap1 chunk1 = reseed, gaps in cycles, chunks in hex
W
W
B
R 0 0123abcd 0 89ef4567
W
W
R 3 deadbeef 5 a5a5c3c3
W
B
R 1 00000000 0 00000001
W
W
R 7 5a5a0ff0 2 13572468
B
W

//--- project.f
common/clr_prng_pkg.sv
common/clr_cnst_pkg.sv
prng/clr_entropy_packer.sv
prng/clr_lfsr.sv
prng/clr_prng.sv
logic/clr_wipe_seq.sv
logic/clr_top.sv
bench/clr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench, the result comes from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module clr_tb -f project.f -o clr_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/clr_sim > sim.log 2>&1
grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
  || grep -q ">>> PASS" sim.log && echo "Simulation passed" \
  || { echo "No result in sim.log"; exit 1; }

//--- bench/clr_tb.sv
// ------------------------------
// Runs from the project root and reads bench/clr_testdata.txt
// ------------------------------
module clr_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned EntropyWidth = 32;
  localparam int unsigned WipeWords    = 4;
  localparam int unsigned CyclesPerCmd = 200;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wipe_i;
  logic                      reseed_i;
  logic                      wipe_valid_o;
  clr_prng_pkg::clr_shares_t wipe_shares_o;
  logic                      done_o;
  logic                      busy_o;
  logic                      entropy_req_o;
  logic                      entropy_ack_i;
  logic [EntropyWidth-1:0]   entropy_i;

  // Reference LFSR state that tracks the DUT state across wipes and reseeds
  clr_prng_pkg::clr_word_t model_state;
  string                   cmds[$];
  int                      errors;
  bit                      cmds_loaded;

  clr_top #(
    .EntropyWidth ( EntropyWidth ),
    .SkipReseed   ( 1'b0         ),
    .WipeWords    ( WipeWords    )
  ) clr_top_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .wipe_i        ( wipe_i        ),
    .reseed_i      ( reseed_i      ),
    .wipe_valid_o  ( wipe_valid_o  ),
    .wipe_shares_o ( wipe_shares_o ),
    .done_o        ( done_o        ),
    .busy_o        ( busy_o        ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

  always #2 clk_i = ~clk_i;

  // One Galois step shifts right and folds bit 0 back through the taps
  function automatic clr_prng_pkg::clr_word_t galois_step(clr_prng_pkg::clr_word_t s);
    return (s >> 1) ^ (s[0] ? clr_cnst_pkg::LfsrTaps : 64'd0);
  endfunction

  // Applies the permutation, the S-box on every nibble and the permutation again
  function automatic clr_prng_pkg::clr_word_t scramble(clr_prng_pkg::clr_word_t s);
    clr_prng_pkg::clr_word_t p;
    clr_prng_pkg::clr_word_t x;
    clr_prng_pkg::clr_word_t r;
    for (int i = 0; i < 64; i++) p[i] = s[clr_cnst_pkg::LfsrPerm[i]];
    for (int n = 0; n < 16; n++) x[4*n +: 4] = clr_cnst_pkg::PrinceSbox[p[4*n +: 4]];
    for (int i = 0; i < 64; i++) r[i] = x[clr_cnst_pkg::LfsrPerm[i]];
    return r;
  endfunction

  function automatic clr_prng_pkg::clr_shares_t expected_shares(clr_prng_pkg::clr_word_t s);
    clr_prng_pkg::clr_shares_t e;
    e.share0 = scramble(s);
    for (int i = 0; i < 64; i++) e.share1[i] = e.share0[clr_cnst_pkg::SharePerm[i]];
    return e;
  endfunction

  task automatic report_failure(string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_shares(clr_prng_pkg::clr_shares_t act, clr_prng_pkg::clr_shares_t exp);
    if (act !== exp) begin
      report_failure($sformatf("shares %h/%h, expected %h/%h",
                               act.share0, act.share1, exp.share0, exp.share1));
    end
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      report_failure($sformatf("%s is %b, expected %b", name, act, exp));
    end
  endtask

  // Checks every word of one wipe up to done_o
  // With extra_pulse set a second wipe pulse lands while the sequencer is busy
  task automatic collect_words(bit extra_pulse);
    int words;
    int iter;
    bit prev_valid;
    words      = 0;
    iter       = 0;
    prev_valid = 1'b0;
    forever begin
      @(negedge clk_i);
      check_bit("entropy_req_o during wipe", entropy_req_o, 1'b0);
      if (wipe_valid_o) begin
        check_shares(wipe_shares_o, expected_shares(model_state));
        model_state = galois_step(model_state);
        words++;
      end
      if (done_o) begin
        check_bit("done_o one cycle after the last word", prev_valid & ~wipe_valid_o, 1'b1);
        check_bit("word count at done", words == WipeWords, 1'b1);
        break;
      end
      prev_valid = wipe_valid_o;
      if (extra_pulse && iter == 1) check_bit("busy_o at extra wipe", busy_o, 1'b1);
      @(posedge clk_i);
      wipe_i <= extra_pulse && (iter == 1);
      iter++;
    end
    // A wipe that was wrongly accepted would show up here
    repeat (3) begin
      @(posedge clk_i);
      wipe_i <= 1'b0;
      @(negedge clk_i);
      check_bit("wipe_valid_o after done", wipe_valid_o, 1'b0);
      check_bit("done_o after done", done_o, 1'b0);
    end
  endtask

  task automatic run_wipe(bit extra_pulse);
    @(posedge clk_i);
    wipe_i <= 1'b1;
    @(posedge clk_i);
    wipe_i <= 1'b0;
    collect_words(extra_pulse);
  endtask

  task automatic deliver_chunk(int gap, logic [EntropyWidth-1:0] chunk);
    repeat (gap) begin
      @(negedge clk_i);
      check_bit("entropy_req_o during gap", entropy_req_o, 1'b1);
      check_bit("wipe_valid_o during reseed", wipe_valid_o, 1'b0);
      @(posedge clk_i);
    end
    entropy_ack_i <= 1'b1;
    entropy_i     <= chunk;
    @(negedge clk_i);
    check_bit("entropy_req_o at chunk", entropy_req_o, 1'b1);
    check_bit("wipe_valid_o during reseed", wipe_valid_o, 1'b0);
    @(posedge clk_i);
    entropy_ack_i <= 1'b0;
  endtask

  // A wipe starts in the same cycle as the reseed and waits for the new seed
  task automatic run_reseed(int g0, logic [31:0] c0, int g1, logic [31:0] c1);
    @(posedge clk_i);
    reseed_i <= 1'b1;
    wipe_i   <= 1'b1;
    @(posedge clk_i);
    reseed_i <= 1'b0;
    wipe_i   <= 1'b0;
    deliver_chunk(g0, c0);
    deliver_chunk(g1, c1);
    // First chunk forms the upper half of the seed
    model_state = {c0, c1};
    collect_words(1'b0);
  endtask

  initial begin
    wait (cmds_loaded);
    #((cmds.size() * CyclesPerCmd + 20) * 4);
    $display("Timeout, the DUT stopped responding");
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    string       tag;
    int          g0;
    int          g1;
    logic [31:0] c0;
    logic [31:0] c1;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    wipe_i        = 1'b0;
    reseed_i      = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    errors        = 0;
    model_state   = clr_cnst_pkg::LfsrSeedDefault;
    fd = $fopen("bench/clr_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      $display(">>> FAIL");
      $fatal(1, "No test data");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") cmds.push_back(line);
    end
    $fclose(fd);
    cmds_loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (cmds[k]) begin
      n = $sscanf(cmds[k], "%s %d %h %d %h", tag, g0, c0, g1, c1);
      if (tag == "W") run_wipe(1'b0);
      else if (tag == "B") run_wipe(1'b1);
      else if (tag == "R" && n == 5) run_reseed(g0, c0, g1, c1);
      else report_failure($sformatf("bad command line %s", cmds[k]));
    end
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- logic/clr_top.sv
// ------------------------------
// Word width is fixed at 64. EntropyWidth must divide it
// ------------------------------
module clr_top #(
  parameter int unsigned EntropyWidth = 32,
  parameter bit          SkipReseed   = 1'b0,
  parameter int unsigned WipeWords    = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wipe_i,
  input  logic                      reseed_i,
  output logic                      wipe_valid_o,
  output clr_prng_pkg::clr_shares_t wipe_shares_o,
  output logic                      done_o,
  output logic                      busy_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [EntropyWidth-1:0]   entropy_i
);

  // Request and ack levels between the sequencer and the generator
  logic data_req;
  logic data_ack;
  logic reseed_req;
  logic reseed_ack;

  clr_wipe_seq #(
    .WipeWords ( WipeWords )
  ) clr_wipe_seq_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .wipe_i       ( wipe_i       ),
    .reseed_i     ( reseed_i     ),
    .data_req_o   ( data_req     ),
    .data_ack_i   ( data_ack     ),
    .reseed_req_o ( reseed_req   ),
    .reseed_ack_i ( reseed_ack   ),
    .wipe_valid_o ( wipe_valid_o ),
    .done_o       ( done_o       ),
    .busy_o       ( busy_o       )
  );

  clr_prng #(
    .EntropyWidth ( EntropyWidth ),
    .SkipReseed   ( SkipReseed   )
  ) clr_prng_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .data_req_i    ( data_req      ),
    .data_ack_o    ( data_ack      ),
    .reseed_req_i  ( reseed_req    ),
    .reseed_ack_o  ( reseed_ack    ),
    .shares_o      ( wipe_shares_o ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

endmodule

//--- logic/clr_wipe_seq.sv
// ------------------------------
// Wipe pulses are dropped while busy. A reseed pulse during a
// pending reseed merges with it
// ------------------------------
module clr_wipe_seq #(
  parameter int unsigned WipeWords = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wipe_i,
  input  logic reseed_i,
  output logic data_req_o,
  input  logic data_ack_i,
  output logic reseed_req_o,
  input  logic reseed_ack_i,
  output logic wipe_valid_o,
  output logic done_o,
  output logic busy_o
);

  localparam int unsigned CntWidth = $clog2(WipeWords + 1);

  logic                data_req_q;
  logic                reseed_req_q;
  logic                done_q;
  logic [CntWidth-1:0] cnt_q;
  logic                word_taken;
  logic                last_word;
  logic                wipe_start;

  // A word is delivered on every cycle where request and ack meet
  assign word_taken = data_req_q & data_ack_i;
  assign last_word  = word_taken & (cnt_q == CntWidth'(1));
  assign wipe_start = wipe_i & ~busy_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_wipe
    if (!rst_ni) begin
      data_req_q <= 1'b0;
      cnt_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      // Done is a single pulse in the cycle after the last word
      done_q <= last_word;
      if (wipe_start) begin
        data_req_q <= 1'b1;
        cnt_q      <= CntWidth'(WipeWords);
      end else if (word_taken) begin
        cnt_q <= cnt_q - 1'b1;
        if (last_word) begin
          data_req_q <= 1'b0;
        end
      end
    end
  end

  // Reseed request holds until the generator acknowledges the new seed
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_reseed
    if (!rst_ni) begin
      reseed_req_q <= 1'b0;
    end else begin
      reseed_req_q <= reseed_i | (reseed_req_q & ~reseed_ack_i);
    end
  end

  assign data_req_o   = data_req_q;
  assign reseed_req_o = reseed_req_q;
  assign wipe_valid_o = word_taken;
  assign done_o       = done_q;
  assign busy_o       = data_req_q | reseed_req_q;

endmodule

//--- prng/clr_prng.sv
// ------------------------------
// Reseed always beats data. SkipReseed acks reseeds at once and
// leaves the LFSR on its current sequence
// ------------------------------
module clr_prng #(
  parameter int unsigned EntropyWidth = 32,
  parameter bit          SkipReseed   = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      data_req_i,
  output logic                      data_ack_o,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,
  output clr_prng_pkg::clr_shares_t shares_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [EntropyWidth-1:0]   entropy_i
);

  logic                    chunk_valid;
  logic                    seed_valid;
  logic                    seed_en;
  logic                    lfsr_step;
  clr_prng_pkg::clr_word_t seed;
  clr_prng_pkg::clr_word_t lfsr_out;

  // Data is served only when no reseed is waiting
  assign data_ack_o = data_req_i & ~reseed_req_i;
  assign lfsr_step  = data_req_i & data_ack_o;

  // The request drops with reseed_req once the final chunk completes the seed
  assign entropy_req_o = SkipReseed ? 1'b0 : reseed_req_i;
  assign chunk_valid   = entropy_req_o & entropy_ack_i;
  assign reseed_ack_o  = SkipReseed ? reseed_req_i : seed_valid;
  assign seed_en       = SkipReseed ? 1'b0 : seed_valid;

  clr_entropy_packer #(
    .EntropyWidth ( EntropyWidth )
  ) clr_entropy_packer_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .chunk_valid_i ( chunk_valid ),
    .chunk_i       ( entropy_i   ),
    .seed_valid_o  ( seed_valid  ),
    .seed_o        ( seed        )
  );

  clr_lfsr clr_lfsr_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .seed_en_i ( seed_en   ),
    .seed_i    ( seed      ),
    .step_i    ( lfsr_step ),
    .state_o   ( lfsr_out  )
  );

  // Share 1 reorders the share 0 bits so the two shares differ
  always_comb begin : p_shares
    shares_o.share0 = lfsr_out;
    for (int i = 0; i < clr_prng_pkg::WordWidth; i++) begin
      shares_o.share1[i] = lfsr_out[clr_cnst_pkg::SharePerm[i]];
    end
  end

endmodule

//--- prng/clr_lfsr.sv
// ------------------------------
// 64-bit Galois LFSR only. The output is a nonlinear function of
// the state, the state itself is never exposed
// ------------------------------
module clr_lfsr (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    seed_en_i,
  input  clr_prng_pkg::clr_word_t seed_i,
  input  logic                    step_i,
  output clr_prng_pkg::clr_word_t state_o
);

  clr_prng_pkg::clr_word_t state_q;
  clr_prng_pkg::clr_word_t state_next;
  clr_prng_pkg::clr_word_t perm_in;
  clr_prng_pkg::clr_word_t sbox_out;

  // One Galois step shifts right and folds the dropped bit back in through the taps
  assign state_next = {1'b0, state_q[clr_prng_pkg::WordWidth-1:1]} ^
                      (state_q[0] ? clr_cnst_pkg::LfsrTaps : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= clr_cnst_pkg::LfsrSeedDefault;
    end else if (seed_en_i) begin
      // A fresh seed wins over a pending step
      state_q <= seed_i;
    end else if (step_i) begin
      state_q <= state_next;
    end
  end

  // First permutation spreads neighbouring state bits across different S-boxes
  always_comb begin : p_perm_in
    for (int i = 0; i < clr_prng_pkg::WordWidth; i++) begin
      perm_in[i] = state_q[clr_cnst_pkg::LfsrPerm[i]];
    end
  end

  // Nonlinear layer, each nibble goes through the PRINCE S-box
  always_comb begin : p_sbox
    for (int n = 0; n < clr_prng_pkg::NumNibbles; n++) begin
      sbox_out[4*n +: 4] = clr_cnst_pkg::PrinceSbox[perm_in[4*n +: 4]];
    end
  end

  // Same permutation again, so an S-box output does not stay in one nibble
  always_comb begin : p_perm_out
    for (int i = 0; i < clr_prng_pkg::WordWidth; i++) begin
      state_o[i] = sbox_out[clr_cnst_pkg::LfsrPerm[i]];
    end
  end

endmodule

//--- prng/clr_entropy_packer.sv
// ------------------------------
// EntropyWidth must divide 64 and be at most 32. The final chunk
// is not stored, it passes straight into the seed word
// ------------------------------
module clr_entropy_packer #(
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          chunk_valid_i,
  input  logic [EntropyWidth-1:0]       chunk_i,
  output logic                          seed_valid_o,
  output clr_prng_pkg::clr_word_t       seed_o
);

  // Chunks per seed word, and the storage needed for all but the last one
  localparam int unsigned NumChunks = clr_prng_pkg::WordWidth / EntropyWidth;
  localparam int unsigned BufWidth  = clr_prng_pkg::WordWidth - EntropyWidth;
  localparam int unsigned CntWidth  = $clog2(NumChunks);

  logic [BufWidth-1:0] buf_q;
  logic [CntWidth-1:0] cnt_q;
  logic                last_chunk;

  // The count tells how many chunks sit in the buffer already
  assign last_chunk = (cnt_q == CntWidth'(NumChunks - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (chunk_valid_i) begin
      // Wrap back to empty once the word has been handed out
      cnt_q <= last_chunk ? '0 : cnt_q + 1'b1;
    end
  end

  // Older chunks move up so that the first one ends in the top bits
  always_ff @(posedge clk_i) begin : p_buf
    if (chunk_valid_i && !last_chunk) begin
      buf_q <= (buf_q << EntropyWidth) | BufWidth'(chunk_i);
    end
  end

  // The seed is complete in the same cycle as the final chunk
  assign seed_valid_o = chunk_valid_i & last_chunk;
  assign seed_o       = {buf_q, chunk_i};

endmodule

//--- common/clr_cnst_pkg.sv
// ------------------------------
// Constants are valid for 64-bit words only. Both permutation
// tables must hold every index 0..63 exactly once
// ------------------------------
package clr_cnst_pkg;

  // Reset state of the LFSR, must never be zero or the register locks up
  parameter logic [clr_prng_pkg::WordWidth-1:0] LfsrSeedDefault = 64'h3A5C_96E1_0F7B_24D8;

  // Galois feedback mask for a right shifting register
  // Taps at 64, 63, 61 and 60 give a primitive polynomial
  parameter logic [clr_prng_pkg::WordWidth-1:0] LfsrTaps = 64'hD800_0000_0000_0000;

  // State permutation, output bit i takes input bit LfsrPerm[i]
  // Entries are listed from index 63 down to index 0
  parameter logic [clr_prng_pkg::WordWidth-1:0][clr_prng_pkg::PermIdxWidth-1:0] LfsrPerm = {
    6'd58, 6'd45, 6'd32, 6'd19, 6'd6,  6'd57, 6'd44, 6'd31,
    6'd18, 6'd5,  6'd56, 6'd43, 6'd30, 6'd17, 6'd4,  6'd55,
    6'd42, 6'd29, 6'd16, 6'd3,  6'd54, 6'd41, 6'd28, 6'd15,
    6'd2,  6'd53, 6'd40, 6'd27, 6'd14, 6'd1,  6'd52, 6'd39,
    6'd26, 6'd13, 6'd0,  6'd51, 6'd38, 6'd25, 6'd12, 6'd63,
    6'd50, 6'd37, 6'd24, 6'd11, 6'd62, 6'd49, 6'd36, 6'd23,
    6'd10, 6'd61, 6'd48, 6'd35, 6'd22, 6'd9,  6'd60, 6'd47,
    6'd34, 6'd21, 6'd8,  6'd59, 6'd46, 6'd33, 6'd20, 6'd7
  };

  // Permutation deriving share 1 from share 0, same layout as LfsrPerm
  parameter logic [clr_prng_pkg::WordWidth-1:0][clr_prng_pkg::PermIdxWidth-1:0] SharePerm = {
    6'd48, 6'd11, 6'd38, 6'd1,  6'd28, 6'd55, 6'd18, 6'd45,
    6'd8,  6'd35, 6'd62, 6'd25, 6'd52, 6'd15, 6'd42, 6'd5,
    6'd32, 6'd59, 6'd22, 6'd49, 6'd12, 6'd39, 6'd2,  6'd29,
    6'd56, 6'd19, 6'd46, 6'd9,  6'd36, 6'd63, 6'd26, 6'd53,
    6'd16, 6'd43, 6'd6,  6'd33, 6'd60, 6'd23, 6'd50, 6'd13,
    6'd40, 6'd3,  6'd30, 6'd57, 6'd20, 6'd47, 6'd10, 6'd37,
    6'd0,  6'd27, 6'd54, 6'd17, 6'd44, 6'd7,  6'd34, 6'd61,
    6'd24, 6'd51, 6'd14, 6'd41, 6'd4,  6'd31, 6'd58, 6'd21
  };

  // PRINCE S-box, listed from input 15 down to input 0
  parameter logic [15:0][3:0] PrinceSbox = {
    4'h4, 4'hD, 4'h5, 4'hE, 4'h0, 4'h8, 4'h7, 4'h6,
    4'h1, 4'h9, 4'hC, 4'hA, 4'h2, 4'h3, 4'hF, 4'hB
  };

endpackage

//--- common/clr_prng_pkg.sv
// ------------------------------
// Word widths are fixed at 64 bits. The S-box and permutation
// constants exist for that width only
// ------------------------------
package clr_prng_pkg;

  // Width of one LFSR state, seed or wipe word
  parameter int unsigned WordWidth = 64;

  // Number of 4-bit S-box lanes across one word
  parameter int unsigned NumNibbles = WordWidth / 4;

  // Width of one permutation table entry, enough to address any bit of a word
  parameter int unsigned PermIdxWidth = $clog2(WordWidth);

  // One wipe word or one reseed word
  typedef logic [WordWidth-1:0] clr_word_t;

  // The wipe words for both shares of a masked register, presented together
  // Share 0 is the generator output, share 1 is a bit permutation of share 0
  // so that the two shares never receive identical clearing data
  typedef struct packed {
    clr_word_t share0;
    clr_word_t share1;
  } clr_shares_t;

endpackage
